/* microrocPkg.sv */
package microrocPkg;

    //////////////////////////////////////////////////
    // Word and field types
    //////////////////////////////////////////////////
    typedef logic [15:0] ctrlWordT;   // Host control word, opcode on top
    typedef logic [3:0]  opcodeT;     // ctrlWordT[15:12]
    typedef logic [11:0] ctrlValT;    // ctrlWordT[11:0]
    typedef logic [9:0]  dacCodeT;    // Threshold DAC code
    typedef logic [7:0]  headerT;     // Chip header
    typedef logic [5:0]  chanT;       // Channel index 0..63
    typedef logic [1:0]  asicCountT;  // Chained ASICs minus one
    typedef logic [2:0]  wbAdrT;      // Wishbone word address

    // Opcodes
    localparam opcodeT OP_DAC0      = 4'd1;
    localparam opcodeT OP_DAC1      = 4'd2;
    localparam opcodeT OP_DAC2      = 4'd3;
    localparam opcodeT OP_HEADER    = 4'd4;
    localparam opcodeT OP_ASIC_NUM  = 4'd5;
    localparam opcodeT OP_MODE      = 4'd6;  // Bit 0 set means slow control
    localparam opcodeT OP_READ_CHAN = 4'd7;
    localparam opcodeT OP_LOAD      = 4'd10; // Kicks off a shift

    // Register map
    localparam wbAdrT ADR_CMD    = 3'd0;  // Write side
    localparam wbAdrT ADR_STATUS = 3'd0;  // Read side
    localparam wbAdrT ADR_DAC0   = 3'd1;
    localparam wbAdrT ADR_DAC1   = 3'd2;
    localparam wbAdrT ADR_DAC2   = 3'd3;
    localparam wbAdrT ADR_HEADER = 3'd4;
    localparam wbAdrT ADR_CONFIG = 3'd5;  // Mode, ASIC field, read channel

    //////////////////////////////////////////////////
    // Frame shape and pin timing
    //////////////////////////////////////////////////
    localparam int SC_FRAME_BITS   = 38;  // Header + 3 DACs
    localparam int READ_FRAME_BITS = 64;  // One bit per channel
    localparam int SC_PAD_BITS     = READ_FRAME_BITS - SC_FRAME_BITS;
    localparam int BIT_CYCLES      = 4;   // Clocks per shifted bit
    localparam int RSTB_CYCLES     = 4;   // Register reset length

    typedef logic [READ_FRAME_BITS-1:0] frameT;  // Left aligned, MSB out first
    typedef logic [5:0] bitIdxT;                 // Bit position inside a frame
    typedef logic [2:0] cycCntT;                 // Clock count within a phase

    // Power-up parameter values
    localparam dacCodeT   DAC_RST        = 10'd0;
    localparam headerT    HEADER_RST     = 8'hA1;
    localparam asicCountT ASIC_NUM_RST   = 2'd0;
    localparam logic      SC_OR_READ_RST = 1'b1;  // Slow control
    localparam chanT      READ_CHAN_RST  = 6'd0;

    // Decoded parameter bank
    typedef struct packed {
        dacCodeT   dac0;
        dacCodeT   dac1;
        dacCodeT   dac2;
        headerT    header;
        asicCountT asicNum;
        logic      scOrRead;  // 1 slow control, 0 read register
        chanT      readChan;
    } scParamT;

    typedef enum logic [1:0] {
        IDLE,
        RSTB,
        SHIFT,
        DONE
    } scStateT;

endpackage

/* wbCmdPort.sv */
module wbCmdPort (
    input  logic                  Clk,
    input  logic                  rst,
    // Wishbone classic slave
    input  logic                  wbCyc,
    input  logic                  wbStb,
    input  logic                  wbWe,
    input  microrocPkg::wbAdrT    wbAdr,
    input  microrocPkg::ctrlWordT wbDatW,
    output logic [15:0]           wbDatR,
    output logic                  wbAck,
    // Readback sources
    input  microrocPkg::scParamT  params,
    input  logic                  loadBusy,
    input  logic                  configDone,
    // Towards the decoder
    output logic                  cmdValid,
    output microrocPkg::ctrlWordT cmdWord,
    input  logic                  cmdReady
);

    logic        cycActive;  // Request not yet acked
    logic        wrCmd;      // Control word write
    logic        takeCmd;    // Word goes into the holding register
    logic        cmdFull;
    logic [15:0] rdData;

    assign cycActive = wbCyc && wbStb && !wbAck;  // Ack gates off the second clock
    assign wrCmd     = cycActive && wbWe && (wbAdr == microrocPkg::ADR_CMD);
    // Room when empty or when the old word leaves this clock
    assign takeCmd   = wrCmd && (!cmdFull || cmdReady);
    assign cmdValid  = cmdFull;

    //////////////////////////////////////////////////
    // Single entry command buffer and ack
    //////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (rst) begin
            wbAck   <= 1'b0;
            cmdFull <= 1'b0;
        end else begin
            wbAck <= cycActive && (!wrCmd || takeCmd);  // Full buffer holds the ack back
            if (takeCmd)
                cmdFull <= 1'b1;
            else if (cmdReady)
                cmdFull <= 1'b0;  // Handed to decoder
        end
    end

    always_ff @(posedge Clk) begin
        if (takeCmd)
            cmdWord <= wbDatW;
    end

    //////////////////////////////////////////////////
    // Readback mux
    //////////////////////////////////////////////////
    always_comb begin
        case (wbAdr)
            microrocPkg::ADR_STATUS: rdData = {14'd0, configDone, loadBusy};
            microrocPkg::ADR_DAC0:   rdData = {6'd0, params.dac0};
            microrocPkg::ADR_DAC1:   rdData = {6'd0, params.dac1};
            microrocPkg::ADR_DAC2:   rdData = {6'd0, params.dac2};
            microrocPkg::ADR_HEADER: rdData = {8'd0, params.header};
            microrocPkg::ADR_CONFIG: begin
                // Channel in 13:8, ASIC field in 2:1, mode in 0
                rdData = {2'd0, params.readChan, 5'd0, params.asicNum, params.scOrRead};
            end
            default:                 rdData = 16'd0;  // Unmapped
        endcase
    end

    // Data lines up with the ack
    always_ff @(posedge Clk) begin
        if (cycActive && !wbWe)
            wbDatR <= rdData;
    end

endmodule

/* ctrlWordDecoder.sv */
module ctrlWordDecoder (
    input  logic                  Clk,
    input  logic                  rst,
    // From the host port
    input  logic                  cmdValid,
    input  microrocPkg::ctrlWordT cmdWord,
    output logic                  cmdReady,
    // Serializer side
    input  logic                  loadBusy,
    output microrocPkg::scParamT  params,
    output logic                  loadReq
);

    microrocPkg::opcodeT  opcode;
    microrocPkg::ctrlValT value;
    logic                 isLoad;
    logic                 loadStall;  // Load word has to wait
    logic                 accept;     // Word transfer this clock

    //////////////////////////////////////////////////
    // Word split and handshake
    //////////////////////////////////////////////////
    assign opcode = cmdWord[15:12];
    assign value  = cmdWord[11:0];
    assign isLoad = (opcode == microrocPkg::OP_LOAD);

    // A pending pulse counts as busy too,
    // the serializer sees it only one clock later
    assign loadStall = isLoad && (loadBusy || loadReq);
    assign cmdReady  = !loadStall;  // Parameter words never stall
    assign accept    = cmdValid && cmdReady;

    //////////////////////////////////////////////////
    // Parameter bank
    //////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (rst) begin
            params.dac0     <= microrocPkg::DAC_RST;
            params.dac1     <= microrocPkg::DAC_RST;
            params.dac2     <= microrocPkg::DAC_RST;
            params.header   <= microrocPkg::HEADER_RST;
            params.asicNum  <= microrocPkg::ASIC_NUM_RST;
            params.scOrRead <= microrocPkg::SC_OR_READ_RST;  // Slow control
            params.readChan <= microrocPkg::READ_CHAN_RST;
        end else if (accept) begin
            case (opcode)
                microrocPkg::OP_DAC0: begin
                    params.dac0 <= value[9:0];
                end
                microrocPkg::OP_DAC1: begin
                    params.dac1 <= value[9:0];
                end
                microrocPkg::OP_DAC2: begin
                    params.dac2 <= value[9:0];
                end
                microrocPkg::OP_HEADER: begin
                    params.header <= value[7:0];
                end
                microrocPkg::OP_ASIC_NUM: begin
                    params.asicNum <= value[1:0];  // Chain length minus one
                end
                microrocPkg::OP_MODE: begin
                    params.scOrRead <= value[0];  // 0 selects read register
                end
                microrocPkg::OP_READ_CHAN: begin
                    params.readChan <= value[5:0];
                end
                default: begin
                    // Load word or unknown opcode, bank untouched
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Load request
    //////////////////////////////////////////////////
    // One clock wide, never while a shift runs
    always_ff @(posedge Clk) begin
        if (rst)
            loadReq <= 1'b0;
        else
            loadReq <= accept && isLoad;
    end

endmodule

/* scSerializer.sv */
module scSerializer (
    input  logic                 Clk,
    input  logic                 rst,
    input  microrocPkg::scParamT params,
    input  logic                 loadReq,
    output logic                 loadBusy,
    // Microroc daisy chain pins
    output logic                 select,      // 1 slow control, 0 read register
    output logic                 srRstb,      // Register reset, active low
    output logic                 srCk,
    output logic                 srIn,
    output logic                 configDone
);

    microrocPkg::scStateT   state;
    microrocPkg::scParamT   snap;      // Parameters frozen at load
    microrocPkg::frameT     frame;     // Frame built from the snapshot
    microrocPkg::frameT     shiftReg;
    microrocPkg::bitIdxT    bitCnt;
    microrocPkg::bitIdxT    lastBit;
    microrocPkg::asicCountT asicCnt;
    microrocPkg::cycCntT    cycCnt;    // Clock within reset or bit period
    logic                   rstbEnd;
    logic                   bitEnd;
    logic                   frameEnd;
    logic                   chainEnd;

    //////////////////////////////////////////////////
    // Frame build
    //////////////////////////////////////////////////
    always_comb begin
        if (snap.scOrRead) begin
            // Header, DAC2, DAC1, DAC0, each MSB first
            frame = {snap.header, snap.dac2, snap.dac1, snap.dac0,
                     {microrocPkg::SC_PAD_BITS{1'b0}}};
        end else begin
            frame = microrocPkg::frameT'(1) << snap.readChan;  // One-hot read register
        end
    end

    assign lastBit = snap.scOrRead ? microrocPkg::bitIdxT'(microrocPkg::SC_FRAME_BITS - 1)
                                   : microrocPkg::bitIdxT'(microrocPkg::READ_FRAME_BITS - 1);

    // Period ends
    assign rstbEnd  = (state == microrocPkg::RSTB) &&
                      (cycCnt == microrocPkg::cycCntT'(microrocPkg::RSTB_CYCLES - 1));
    assign bitEnd   = (state == microrocPkg::SHIFT) &&
                      (cycCnt == microrocPkg::cycCntT'(microrocPkg::BIT_CYCLES - 1));
    assign frameEnd = bitEnd && (bitCnt == lastBit);
    assign chainEnd = frameEnd && (asicCnt == snap.asicNum);  // Last ASIC done

    //////////////////////////////////////////////////
    // FSM
    //////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (rst) begin
            state <= microrocPkg::IDLE;
        end else begin
            case (state)
                microrocPkg::IDLE,
                microrocPkg::DONE: if (loadReq) state <= microrocPkg::RSTB;
                microrocPkg::RSTB: if (rstbEnd) state <= microrocPkg::SHIFT;
                microrocPkg::SHIFT: if (chainEnd) state <= microrocPkg::DONE;
                default: state <= microrocPkg::IDLE;
            endcase
        end
    end

    // Phase, bit and ASIC counters
    always_ff @(posedge Clk) begin
        if (rst) begin
            cycCnt  <= '0;
            bitCnt  <= '0;
            asicCnt <= '0;
        end else begin
            case (state)
                microrocPkg::RSTB: begin
                    cycCnt  <= rstbEnd ? '0 : cycCnt + 1'b1;
                    bitCnt  <= '0;
                    asicCnt <= '0;
                end
                microrocPkg::SHIFT: begin
                    cycCnt <= bitEnd ? '0 : cycCnt + 1'b1;
                    if (bitEnd)
                        bitCnt <= frameEnd ? '0 : bitCnt + 1'b1;  // Wrap per ASIC
                    if (frameEnd)
                        asicCnt <= asicCnt + 1'b1;
                end
                default: begin
                    cycCnt <= '0;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Snapshot and shift register
    //////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (loadReq && !loadBusy)
            snap <= params;  // Later bank writes wait for the next load
        if (rstbEnd || (frameEnd && !chainEnd))
            shiftReg <= frame;  // Fresh copy for each chained ASIC
        else if (bitEnd)
            shiftReg <= shiftReg << 1;
    end

    //////////////////////////////////////////////////
    // Pin decode
    //////////////////////////////////////////////////
    assign loadBusy   = (state == microrocPkg::RSTB) || (state == microrocPkg::SHIFT);
    assign configDone = (state == microrocPkg::DONE);  // Held until next load
    assign srRstb     = (state != microrocPkg::RSTB);
    // High for last two clocks of a bit, srIn settled two clocks before
    assign srCk       = (state == microrocPkg::SHIFT) &&
                        (cycCnt >= microrocPkg::cycCntT'(microrocPkg::BIT_CYCLES - 2));
    assign srIn       = (state == microrocPkg::SHIFT) && shiftReg[microrocPkg::READ_FRAME_BITS-1];
    assign select     = loadBusy ? snap.scOrRead : params.scOrRead;  // Live mode while idle

endmodule

/* microrocScTop.sv */
module microrocScTop (
    input  logic                  Clk,
    input  logic                  rst,
    // Host bus
    input  logic                  wbCyc,
    input  logic                  wbStb,
    input  logic                  wbWe,
    input  microrocPkg::wbAdrT    wbAdr,
    input  microrocPkg::ctrlWordT wbDatW,
    output logic [15:0]           wbDatR,
    output logic                  wbAck,
    // ASIC chain
    output logic                  select,
    output logic                  srRstb,
    output logic                  srCk,
    output logic                  srIn,
    output logic                  configDone
);

    logic                  cmdValid;
    microrocPkg::ctrlWordT cmdWord;
    logic                  cmdReady;
    microrocPkg::scParamT  params;    // Live parameter bank
    logic                  loadReq;
    logic                  loadBusy;

    //////////////////////////////////////////////////
    // Host port, decoder, serializer
    //////////////////////////////////////////////////
    wbCmdPort u_wbCmdPort (
        .Clk       (Clk),
        .rst       (rst),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck),
        .params    (params),
        .loadBusy  (loadBusy),    // Status bit 0
        .configDone(configDone),  // Status bit 1
        .cmdValid  (cmdValid),
        .cmdWord   (cmdWord),
        .cmdReady  (cmdReady)
    );

    ctrlWordDecoder u_ctrlWordDecoder (
        .Clk     (Clk),
        .rst     (rst),
        .cmdValid(cmdValid),
        .cmdWord (cmdWord),
        .cmdReady(cmdReady),
        .loadBusy(loadBusy),
        .params  (params),
        .loadReq (loadReq)
    );

    scSerializer u_scSerializer (
        .Clk       (Clk),
        .rst       (rst),
        .params    (params),
        .loadReq   (loadReq),
        .loadBusy  (loadBusy),
        .select    (select),
        .srRstb    (srRstb),
        .srCk      (srCk),
        .srIn      (srIn),
        .configDone(configDone)
    );

endmodule

/* tbMicrorocSc_properties.sv */
module tbMicrorocSc_properties (
    input logic                  Clk,
    input logic                  rst,
    input logic                  wbCyc,
    input logic                  wbStb,
    input logic                  wbWe,
    input microrocPkg::wbAdrT    wbAdr,
    input microrocPkg::ctrlWordT wbDatW,
    input logic                  wbAck,
    input logic                  loadBusy,   // Serializer internal
    input logic                  loadReq,    // Decoder internal
    input logic                  select,
    input logic                  srRstb,
    input logic                  srCk,
    input logic                  srIn,
    input logic                  configDone
);

    microrocPkg::scParamT shadow;     // Bank as written by the host
    microrocPkg::scParamT cur;        // Parameters of the running shift
    microrocPkg::scParamT pendQ[$];   // Loads acked but not started
    int                   pendCnt;
    int                   edgeCnt;    // srCk rises since srRstb fell
    int                   rstbLen;    // Length of last srRstb pulse
    int                   frameBits;
    int                   expEdges;
    logic                 expBit;
    logic                 srCkQ;
    logic                 srRstbQ;
    logic                 wrSeen;
    logic                 failBit   = 1'b0;
    logic                 failEdges = 1'b0;
    logic                 failDone  = 1'b0;
    logic                 failRstb  = 1'b0;
    logic                 failSel   = 1'b0;
    logic                 failReq   = 1'b0;
    logic                 failQueue = 1'b0;
    logic                 failPulse = 1'b0;
    logic                 failAck   = 1'b0;
    logic                 anyFail;

    // Bit k of a frame in shift order
    function automatic logic frameBit(input microrocPkg::scParamT p, input int k);
        logic [37:0] scBits;
        scBits = {p.header, p.dac2, p.dac1, p.dac0};
        if (!p.scOrRead)
            return (k + int'(p.readChan)) == 63;  // Bit 63 goes out first
        scBits = scBits << k;
        return scBits[37];
    endfunction

    assign wrSeen  = wbAck && wbWe && (wbAdr == 3'd0);  // Master holds adr and data
    assign anyFail = failBit | failEdges | failDone | failRstb | failSel |
                     failReq | failQueue | failPulse | failAck;

    //////////////////////////////////////////////////
    // Shadow model
    //////////////////////////////////////////////////
    always @(posedge Clk) begin
        if (rst) begin
            shadow.dac0     <= 10'd0;
            shadow.dac1     <= 10'd0;
            shadow.dac2     <= 10'd0;
            shadow.header   <= 8'hA1;
            shadow.asicNum  <= 2'd0;
            shadow.scOrRead <= 1'b1;
            shadow.readChan <= 6'd0;
            cur     <= '0;
            pendQ.delete();
            pendCnt <= 0;
            edgeCnt <= 0;
            rstbLen <= 0;
            srCkQ   <= 1'b0;
            srRstbQ <= 1'b1;
        end else begin
            if (wrSeen) begin
                case (wbDatW[15:12])
                    4'd1:    shadow.dac0     <= wbDatW[9:0];
                    4'd2:    shadow.dac1     <= wbDatW[9:0];
                    4'd3:    shadow.dac2     <= wbDatW[9:0];
                    4'd4:    shadow.header   <= wbDatW[7:0];
                    4'd5:    shadow.asicNum  <= wbDatW[1:0];
                    4'd6:    shadow.scOrRead <= wbDatW[0];
                    4'd7:    shadow.readChan <= wbDatW[5:0];
                    4'd10:   pendQ.push_back(shadow);  // Frame fixed by bus order
                    default: ;
                endcase
            end
            srCkQ   <= srCk;
            srRstbQ <= srRstb;
            if (srRstbQ && !srRstb) begin  // Shift starts
                if (pendQ.size() > 0)
                    cur <= pendQ.pop_front();
                edgeCnt <= 0;
            end else if (srCk && !srCkQ) begin
                edgeCnt <= edgeCnt + 1;
            end
            if (!srRstb)
                rstbLen <= srRstbQ ? 1 : rstbLen + 1;
            pendCnt <= pendQ.size();
        end
    end

    always_comb begin
        frameBits = cur.scOrRead ? microrocPkg::SC_FRAME_BITS : microrocPkg::READ_FRAME_BITS;
        expEdges  = frameBits * (int'(cur.asicNum) + 1);  // Frame repeats per ASIC
        expBit    = frameBit(cur, edgeCnt % frameBits);
    end

    //////////////////////////////////////////////////
    // Pin and bus properties
    //////////////////////////////////////////////////
    a_srInBit: assert property (@(posedge Clk) disable iff (rst)
        $rose(srCk) |-> srIn == expBit)
        else begin
            failBit = 1'b1;
            $error("[FAIL] %0t srIn at edge %0d: expected %0b, actual %0b",
                   $time, $sampled(edgeCnt), $sampled(expBit), $sampled(srIn));
        end
    a_edgeCount: assert property (@(posedge Clk) disable iff (rst)
        $fell(loadBusy) |-> edgeCnt == expEdges)
        else begin
            failEdges = 1'b1;
            $error("[FAIL] %0t srCk edge count: expected %0d, actual %0d",
                   $time, $sampled(expEdges), $sampled(edgeCnt));
        end
    a_doneAtEnd: assert property (@(posedge Clk) disable iff (rst)
        $fell(loadBusy) |-> configDone)
        else begin
            failDone = 1'b1;
            $error("[FAIL] %0t configDone: expected %0b, actual %0b",
                   $time, 1'b1, $sampled(configDone));
        end
    a_rstbFirst: assert property (@(posedge Clk) disable iff (rst)
        $rose(srCk) |-> srRstb && rstbLen == microrocPkg::RSTB_CYCLES)
        else begin
            failRstb = 1'b1;
            $error("srCk without a full srRstb pulse");
        end
    a_selectShift: assert property (@(posedge Clk) disable iff (rst)
        $rose(srCk) |-> select == cur.scOrRead)
        else begin
            failSel = 1'b1;
            $error("[FAIL] %0t select: expected %0b, actual %0b",
                   $time, $sampled(cur.scOrRead), $sampled(select));
        end
    a_noReqBusy: assert property (@(posedge Clk) disable iff (rst)
        loadReq |-> !loadBusy)
        else begin
            failReq = 1'b1;
            $error("loadReq while loadBusy");
        end
    a_loadQueued: assert property (@(posedge Clk) disable iff (rst)
        $fell(srRstb) |-> pendCnt > 0)
        else begin
            failQueue = 1'b1;
            $error("shift started with no load on the bus");
        end
    a_ackPulse: assert property (@(posedge Clk) disable iff (rst)
        wbAck |=> !wbAck)
        else begin
            failPulse = 1'b1;
            $error("wbAck longer than one clock");
        end
    a_ackReq: assert property (@(posedge Clk) disable iff (rst)
        wbAck |-> $past(wbCyc && wbStb))
        else begin
            failAck = 1'b1;
            $error("wbAck without a request");
        end

endmodule

/* tbMicrorocSc.sv */
module tbMicrorocSc;

    localparam int ACK_TIMEOUT   = 20;    // Clocks
    localparam int START_TIMEOUT = 20;
    localparam int DONE_TIMEOUT  = 1200;  // Four read frames plus margin

    logic                  Clk;
    logic                  rst;
    logic                  wbCyc;
    logic                  wbStb;
    logic                  wbWe;
    microrocPkg::wbAdrT    wbAdr;
    microrocPkg::ctrlWordT wbDatW;
    logic [15:0]           wbDatR;
    logic                  wbAck;
    logic                  select;
    logic                  srRstb;
    logic                  srCk;
    logic                  srIn;
    logic                  configDone;
    logic [31:0]           lfsrState;
    microrocPkg::scParamT  expParams;  // Bank as the host expects it

    microrocScTop u_microrocScTop (
        .Clk(Clk), .rst(rst),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
        .select(select), .srRstb(srRstb), .srCk(srCk), .srIn(srIn),
        .configDone(configDone)
    );

    bind microrocScTop tbMicrorocSc_properties u_props (
        .Clk(Clk), .rst(rst), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbDatW(wbDatW), .wbAck(wbAck), .loadBusy(loadBusy),
        .loadReq(loadReq), .select(select), .srRstb(srRstb), .srCk(srCk),
        .srIn(srIn), .configDone(configDone)
    );

    always #50 Clk = ~Clk;

    always @(negedge Clk) begin
        if (u_microrocScTop.u_props.anyFail)
            failRun("a property of the bound checker failed");
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic checkEq(input string name, input logic [15:0] exp, input logic [15:0] act);
        assert (act === exp)
        else failRun($sformatf("[FAIL] %0t %s: expected 0x%04h, actual 0x%04h",
                               $time, name, exp, act));
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randBits(input int n, output logic [15:0] r);
        int i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);  // One step per bit
            r = {r[14:0], lfsrState[0]};
        end
    endtask

    task automatic waitAck(input string kind);
        int n;
        n = 0;
        @(negedge Clk);
        while (!wbAck && n < ACK_TIMEOUT) begin
            @(negedge Clk);
            n++;
        end
        if (!wbAck)
            failRun($sformatf("Wishbone %s got no ack within %0d clocks", kind, ACK_TIMEOUT));
        wbCyc = 1'b0;
        wbStb = 1'b0;  // Address and data stay put
    endtask

    task automatic busWrite(input microrocPkg::wbAdrT adr, input microrocPkg::ctrlWordT data);
        @(negedge Clk);
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = 1'b1;
        wbAdr  = adr;
        wbDatW = data;
        waitAck("write");
    endtask

    task automatic busRead(input microrocPkg::wbAdrT adr, output logic [15:0] data);
        @(negedge Clk);
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe  = 1'b0;
        wbAdr = adr;
        waitAck("read");
        data = wbDatR;  // Registered alongside ack
    endtask

    task automatic writeParam(input microrocPkg::opcodeT op, input microrocPkg::ctrlValT val);
        busWrite(3'd0, {op, val});
        case (op)
            4'd1:    expParams.dac0     = val[9:0];
            4'd2:    expParams.dac1     = val[9:0];
            4'd3:    expParams.dac2     = val[9:0];
            4'd4:    expParams.header   = val[7:0];
            4'd5:    expParams.asicNum  = val[1:0];
            4'd6:    expParams.scOrRead = val[0];
            4'd7:    expParams.readChan = val[5:0];
            default: ;  // Load or unknown
        endcase
    endtask

    task automatic checkReadback();
        logic [15:0] d;
        busRead(3'd1, d);
        checkEq("dac0", {6'd0, expParams.dac0}, d);
        busRead(3'd2, d);
        checkEq("dac1", {6'd0, expParams.dac1}, d);
        busRead(3'd3, d);
        checkEq("dac2", {6'd0, expParams.dac2}, d);
        busRead(3'd4, d);
        checkEq("header", {8'd0, expParams.header}, d);
        busRead(3'd5, d);
        checkEq("config", {2'd0, expParams.readChan, 5'd0, expParams.asicNum,
                           expParams.scOrRead}, d);
    endtask

    task automatic randomizeParams();
        logic [15:0] r;
        randBits(10, r);
        writeParam(4'd1, {2'd0, r[9:0]});
        randBits(10, r);
        writeParam(4'd2, {2'd0, r[9:0]});
        randBits(10, r);
        writeParam(4'd3, {2'd0, r[9:0]});
        randBits(8, r);
        writeParam(4'd4, {4'd0, r[7:0]});
        randBits(6, r);
        writeParam(4'd7, {6'd0, r[5:0]});
        randBits(2, r);
        writeParam(4'd5, {10'd0, r[1:0]});  // Chain of one to four
    endtask

    task automatic waitLoadStart();
        int n;
        n = 0;
        while (srRstb && n < START_TIMEOUT) begin
            @(negedge Clk);
            n++;
        end
        if (srRstb)
            failRun("load never started, srRstb stayed high");
        checkEq("configDone", 16'd0, 16'(configDone));
    endtask

    task automatic waitLoadDone(input logic expSel);
        int n;
        n = 0;
        while (!configDone && n < DONE_TIMEOUT) begin
            checkEq("select", 16'(expSel), 16'(select));  // Fixed for the whole load
            @(negedge Clk);
            n++;
        end
        if (!configDone)
            failRun("configDone did not rise before the shift timeout");
    endtask

    //////////////////////////////////////////////////
    // Scenarios
    //////////////////////////////////////////////////
    initial begin
        logic [15:0]         r;
        logic [15:0]         d;
        microrocPkg::opcodeT op;
        int                  i;
        Clk       = 1'b0;
        rst       = 1'b1;
        wbCyc     = 1'b0;
        wbStb     = 1'b0;
        wbWe      = 1'b0;
        wbAdr     = 3'd0;
        wbDatW    = 16'd0;
        lfsrState = 32'h8935_46c8;
        expParams.dac0     = 10'd0;
        expParams.dac1     = 10'd0;
        expParams.dac2     = 10'd0;
        expParams.header   = 8'hA1;
        expParams.asicNum  = 2'd0;
        expParams.scOrRead = 1'b1;
        expParams.readChan = 6'd0;
        repeat (3) @(posedge Clk);
        @(negedge Clk);
        rst = 1'b0;

        // Reset values
        checkEq("configDone", 16'd0, 16'(configDone));
        checkEq("select", 16'd1, 16'(select));
        busRead(3'd0, d);
        checkEq("status", 16'd0, d);
        checkReadback();

        // Random writes, load opcode swapped for an unknown one
        for (i = 0; i < 20; i++) begin
            randBits(4, r);
            op = r[3:0];
            if (op == 4'd10)
                op = 4'hF;
            randBits(12, r);
            writeParam(op, r[11:0]);
        end
        checkReadback();
        writeParam(4'hC, 12'hFFF);
        writeParam(4'h0, 12'h3C5);
        checkReadback();

        // Slow control load, status during and after
        randomizeParams();
        writeParam(4'd6, 12'h001);
        writeParam(4'd10, 12'h000);
        waitLoadStart();
        busRead(3'd0, d);
        checkEq("status", 16'h0001, d);
        waitLoadDone(1'b1);
        busRead(3'd0, d);
        checkEq("status", 16'h0002, d);

        // Read register load
        randomizeParams();
        writeParam(4'd6, 12'h000);
        writeParam(4'd10, 12'h000);
        waitLoadStart();
        waitLoadDone(1'b0);

        // DAC write and second load during a shift
        writeParam(4'd6, 12'h001);
        writeParam(4'd5, 12'h000);
        writeParam(4'd10, 12'h000);
        waitLoadStart();
        randBits(10, r);
        writeParam(4'd1, {2'd0, r[9:0]});
        writeParam(4'd10, 12'h000);
        waitLoadDone(1'b1);
        waitLoadStart();
        waitLoadDone(1'b1);
        checkReadback();
        repeat (4) @(negedge Clk);  // Let end-of-shift properties fire

        if (u_microrocScTop.u_props.anyFail) begin
            failRun("a property of the bound checker failed");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

/* sources.f */
microrocPkg.sv
wbCmdPort.sv
ctrlWordDecoder.sv
scSerializer.sv
microrocScTop.sv
tbMicrorocSc_properties.sv
tbMicrorocSc.sv

/* Makefile */
# Verilator build of the Microroc slow-control testbench
SIM := obj_dir/VtbMicrorocSc

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): sources.f $(wildcard *.sv)
	verilator --binary --timing --assert -j 0 --top-module tbMicrorocSc -f sources.f

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
